/* Makefile */
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_agc_control
RTL_TOP   = agc_control_top
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) include/agc_consts.svh
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/agc_consts.svh */
`ifndef AGC_CONSTS_SVH
`define AGC_CONSTS_SVH

/////////////////////////////////////////////////////////////////////
// Loop start values
/////////////////////////////////////////////////////////////////////
`define AGC_START_SCALE         17'd1500
`define AGC_START_OFFSET        16'sd0
`define AGC_START_SCALE_DELTA   17'd30
`define AGC_START_OFFSET_DELTA  16'sd25

// Gain rule tuning
`define AGC_TARGET_RMS_SQ       16
`define AGC_RMS_SQ_ERR          0
`define AGC_OFFSET_ERR          5
`define AGC_TIMESCALE_BITS      4       // Mean square is accumulated over 2^N frames
`define AGC_SCALE_MIN_CUTOFF    17'h0012C
`define AGC_SCALE_MAX_CUTOFF    17'h1FBD0

`define AGC_BOOT_DELAY          5'd31   // Cycles before the first write, minus one

/////////////////////////////////////////////////////////////////////
// Downstream AGC module register map
/////////////////////////////////////////////////////////////////////
`define AGC_ADR_CTRL            8'h00   // Control on write, status on read
`define AGC_ADR_SCALE           8'h10
`define AGC_ADR_OFFSET          8'h14

// Control words written to AGC_ADR_CTRL
`define AGC_CMD_RESET           32'h0000_0004
`define AGC_CMD_START           32'h0000_0001
`define AGC_CMD_LOAD            32'h0000_0300
`define AGC_CMD_APPLY           32'h0000_0400

`define AGC_STATUS_DONE_BIT     1
`define AGC_INFO_WORDS          6

`endif

/* source/agc_bus_master.sv */
`timescale 1ns/1ps
`default_nettype none

module agc_bus_master
    import agc_bus_pkg::*, agc_loop_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  bus_cmd_t    cmd_i,
    output wb_req_t     mod_req_o,
    input  wb_rsp_t     mod_rsp_i,
    output logic        done_o,
    output logic [31:0] rdata_o
);

    logic        busy_q;        // Drives cyc and stb
    logic        we_q;
    logic        done_q;
    logic [7:0]  adr_q;
    logic [31:0] dat_q;
    logic [31:0] rdata_q;
    logic        take_cmd;
    logic        finish;

    assign take_cmd = !busy_q && cmd_i.valid;
    assign finish   = busy_q && mod_rsp_i.ack;

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= finish;
            if (take_cmd) begin
                busy_q <= 1'b1;
                we_q   <= cmd_i.we;
            end else if (finish) begin
                busy_q <= 1'b0;     // Late ack just holds the request
                we_q   <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (take_cmd) begin
            adr_q <= cmd_i.adr;
            dat_q <= cmd_i.dat;
        end
        if (finish) rdata_q <= mod_rsp_i.dat;
    end

    assign mod_req_o.cyc = busy_q;
    assign mod_req_o.stb = busy_q;
    assign mod_req_o.we  = we_q;
    assign mod_req_o.adr = adr_q;
    assign mod_req_o.sel = {4{busy_q}};
    assign mod_req_o.dat = dat_q;

    assign done_o  = done_q;
    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* source/agc_bus_pkg.sv */
`default_nettype none

package agc_bus_pkg;

    // Wishbone request, driven by the bus master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone response, driven by the target
    typedef struct packed {
        logic        ack;
        logic        err;
        logic        rty;
        logic [31:0] dat;
    } wb_rsp_t;

    // Upstream register target FSM
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        READ  = 2'd2,
        ACK   = 2'd3
    } target_state_e;

endpackage

`default_nettype wire

/* source/agc_control_top.sv */
`timescale 1ns/1ps
`default_nettype none

module agc_control_top
    import agc_bus_pkg::*, agc_loop_pkg::*;
(
    input  logic    aclk,
    input  logic    wb_rst_i,
    input  logic    agc_reset_i,
    input  wb_req_t ctl_req_i,      // From host
    output wb_rsp_t ctl_rsp_o,
    output wb_req_t mod_req_o,      // To AGC module
    input  wb_rsp_t mod_rsp_i
);

    scale_t      scale_delta;
    offset_t     offset_delta;
    agc_info_t   info;
    bus_cmd_t    cmd;
    logic        cmd_done;
    logic [31:0] cmd_rdata;

    agc_reg_target u_target (
        .aclk           (aclk),
        .wb_rst_i       (wb_rst_i),
        .ctl_req_i      (ctl_req_i),
        .ctl_rsp_o      (ctl_rsp_o),
        .info_i         (info),
        .scale_delta_o  (scale_delta),
        .offset_delta_o (offset_delta)
    );

    agc_loop_sequencer u_sequencer (
        .aclk           (aclk),
        .wb_rst_i       (wb_rst_i),
        .agc_reset_i    (agc_reset_i),
        .cmd_o          (cmd),
        .done_i         (cmd_done),
        .rdata_i        (cmd_rdata),
        .scale_delta_i  (scale_delta),
        .offset_delta_i (offset_delta),
        .info_o         (info)
    );

    agc_bus_master u_master (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .cmd_i     (cmd),
        .mod_req_o (mod_req_o),
        .mod_rsp_i (mod_rsp_i),
        .done_o    (cmd_done),
        .rdata_o   (cmd_rdata)
    );

endmodule

`default_nettype wire

/* source/agc_gain_calc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module agc_gain_calc
    import agc_loop_pkg::*;
(
    input  agc_info_t info_i,
    input  scale_t    scale_delta_i,
    input  offset_t   offset_delta_i,
    input  scale_t    prev_scale_i,
    input  offset_t   prev_offset_i,
    output scale_t    scale_o,
    output offset_t   offset_o
);

    logic [31:0] ms_scaled;         // Mean square per frame
    logic [32:0] above_lim;
    logic [32:0] below_lim;
    scale_t      cur_scale;
    offset_t     cur_offset;

    assign ms_scaled  = info_i.word[1] >> (17 - `AGC_TIMESCALE_BITS);
    assign cur_scale  = info_i.word[4][16:0];
    assign cur_offset = info_i.word[5][15:0];
    assign above_lim  = {1'b0, info_i.word[3]} + 33'(`AGC_OFFSET_ERR);
    assign below_lim  = {1'b0, info_i.word[2]} + 33'(`AGC_OFFSET_ERR);

    // Scale steps one delta toward the target band, clamped at the cutoffs
    always_comb begin
        scale_o = prev_scale_i;
        if (ms_scaled > (`AGC_TARGET_RMS_SQ + `AGC_RMS_SQ_ERR)) begin
            if (cur_scale > `AGC_SCALE_MIN_CUTOFF) scale_o = cur_scale - scale_delta_i;
            else                                   scale_o = cur_scale;
        end else if (ms_scaled < (`AGC_TARGET_RMS_SQ - `AGC_RMS_SQ_ERR)) begin
            if (cur_scale < `AGC_SCALE_MAX_CUTOFF) scale_o = cur_scale + scale_delta_i;
            else                                   scale_o = cur_scale;
        end
    end

    // Offset balances counts above and below
    always_comb begin
        offset_o = prev_offset_i;
        if ({1'b0, info_i.word[2]} > above_lim)      offset_o = cur_offset - offset_delta_i;
        else if ({1'b0, info_i.word[3]} > below_lim) offset_o = cur_offset + offset_delta_i;
    end

endmodule

`default_nettype wire

/* source/agc_loop_pkg.sv */
`default_nettype none

package agc_loop_pkg;

    // Words read back from the AGC module after a sample cycle
    // 1 mean square, 2 count above, 3 count below, 4 scale, 5 offset
    typedef struct packed {
        logic [5:0][31:0] word;
    } agc_info_t;

    typedef logic [16:0]        scale_t;
    typedef logic signed [15:0] offset_t;

    // One downstream bus access, handed from sequencer to master
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } bus_cmd_t;

    typedef enum logic [3:0] {
        BOOT_DELAY, WRITE_SCALE, WRITE_OFFSET,
        LOAD, APPLY, RESET_CMD, START,
        POLL, READ_INFO
    } seq_state_e;

endpackage

`default_nettype wire

/* source/agc_loop_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module agc_loop_sequencer
    import agc_loop_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        agc_reset_i,
    output bus_cmd_t    cmd_o,
    input  logic        done_i,
    input  logic [31:0] rdata_i,
    input  scale_t      scale_delta_i,
    input  offset_t     offset_delta_i,
    output agc_info_t   info_o
);

    seq_state_e state_q;
    logic [4:0] boot_cnt_q;
    logic [2:0] word_idx_q;     // Info word being read
    logic       wait_q;         // Command handed over, waiting on the master
    logic       cmd_done;
    logic       calc_cycle;
    scale_t     scale_q;
    offset_t    offset_q;
    agc_info_t  info_q;
    scale_t     calc_scale;
    offset_t    calc_offset;

    assign cmd_done   = wait_q && done_i;
    assign calc_cycle = (state_q == READ_INFO) && (word_idx_q == 3'(`AGC_INFO_WORDS));

    agc_gain_calc u_gain_calc (
        .info_i         (info_q),
        .scale_delta_i  (scale_delta_i),
        .offset_delta_i (offset_delta_i),
        .prev_scale_i   (scale_q),
        .prev_offset_i  (offset_q),
        .scale_o        (calc_scale),
        .offset_o       (calc_offset)
    );

    /////////////////////////////////////////////////////////////////////
    // Command decode, one access per state
    /////////////////////////////////////////////////////////////////////
    always_comb begin
        cmd_o.valid = !wait_q && !calc_cycle;
        cmd_o.we    = 1'b1;
        cmd_o.adr   = `AGC_ADR_CTRL;
        cmd_o.dat   = 32'h0;
        case (state_q)
            WRITE_SCALE: begin
                cmd_o.adr = `AGC_ADR_SCALE;
                cmd_o.dat = {15'h0, scale_q};
            end
            WRITE_OFFSET: begin
                cmd_o.adr = `AGC_ADR_OFFSET;
                cmd_o.dat = {{16{offset_q[15]}}, offset_q};
            end
            LOAD:      cmd_o.dat = `AGC_CMD_LOAD;
            APPLY:     cmd_o.dat = `AGC_CMD_APPLY;
            RESET_CMD: cmd_o.dat = `AGC_CMD_RESET;
            START:     cmd_o.dat = `AGC_CMD_START;
            POLL:      cmd_o.we  = 1'b0;                // Status read
            READ_INFO: begin
                cmd_o.we  = 1'b0;
                cmd_o.adr = {3'b000, word_idx_q, 2'b00};
            end
            default:   cmd_o.valid = 1'b0;              // Boot delay
        endcase
    end

    /////////////////////////////////////////////////////////////////////
    // Loop FSM
    /////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state_q    <= BOOT_DELAY;
            boot_cnt_q <= `AGC_BOOT_DELAY;
            word_idx_q <= 3'd0;
            wait_q     <= 1'b0;
            scale_q    <= `AGC_START_SCALE;
            offset_q   <= `AGC_START_OFFSET;
            info_q     <= '0;
        end else begin
            if (cmd_o.valid)   wait_q <= 1'b1;
            else if (cmd_done) wait_q <= 1'b0;

            case (state_q)
                BOOT_DELAY: begin
                    if (boot_cnt_q != 5'd0) boot_cnt_q <= boot_cnt_q - 5'd1;
                    else                    state_q    <= WRITE_SCALE;
                end
                WRITE_SCALE:  if (cmd_done) state_q <= WRITE_OFFSET;
                WRITE_OFFSET: if (cmd_done) state_q <= LOAD;
                LOAD:         if (cmd_done) state_q <= APPLY;
                APPLY: begin
                    if (cmd_done) begin
                        state_q        <= RESET_CMD;
                        info_q.word[4] <= {15'h0, scale_q};    // Now in effect downstream
                        info_q.word[5] <= {16'h0, offset_q};
                    end
                end
                RESET_CMD:    if (cmd_done) state_q <= START;
                START:        if (cmd_done) state_q <= POLL;
                POLL: begin
                    // Not done yet just reissues the read
                    if (cmd_done && rdata_i[`AGC_STATUS_DONE_BIT]) begin
                        state_q    <= READ_INFO;
                        word_idx_q <= 3'd0;
                    end
                end
                READ_INFO: begin
                    if (calc_cycle) begin
                        scale_q    <= calc_scale;
                        offset_q   <= calc_offset;
                        word_idx_q <= 3'd0;
                        state_q    <= WRITE_SCALE;
                    end else if (cmd_done) begin
                        info_q.word[word_idx_q] <= rdata_i;
                        word_idx_q              <= word_idx_q + 3'd1;
                    end
                end
                default: state_q <= BOOT_DELAY;
            endcase
        end
    end

    assign info_o = info_q;

endmodule

`default_nettype wire

/* source/agc_reg_target.sv */
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module agc_reg_target
    import agc_bus_pkg::*, agc_loop_pkg::*;
(
    input  logic      aclk,
    input  logic      wb_rst_i,
    input  wb_req_t   ctl_req_i,
    output wb_rsp_t   ctl_rsp_o,
    input  agc_info_t info_i,
    output scale_t    scale_delta_o,
    output offset_t   offset_delta_o
);

    target_state_e state_q;
    logic [31:0]   rsp_dat_q;       // Read data, loaded in READ
    logic [31:0]   rd_dat;
    logic [3:0]    word_sel;
    scale_t        scale_delta_q;
    offset_t       offset_delta_q;

    assign word_sel = ctl_req_i.adr[5:2];

    // Read-back mux. Bit 6 picks loop deltas over stored AGC info
    always_comb begin
        rd_dat = 32'h0;
        if (ctl_req_i.adr[6]) begin
            if (word_sel == 4'd0)
                rd_dat = {15'h0, scale_delta_q};
            else if (word_sel == 4'd1)
                rd_dat = {{16{offset_delta_q[15]}}, offset_delta_q};
        end else if (word_sel < `AGC_INFO_WORDS) begin
            rd_dat = info_i.word[word_sel[2:0]];
        end
    end

    /////////////////////////////////////////////////////////////////////
    // Target FSM and delta registers
    /////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state_q        <= IDLE;
            scale_delta_q  <= `AGC_START_SCALE_DELTA;
            offset_delta_q <= `AGC_START_OFFSET_DELTA;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ctl_req_i.cyc && ctl_req_i.stb) begin
                        if (ctl_req_i.we) state_q <= WRITE;
                        else              state_q <= READ;
                    end
                end
                READ:    state_q <= ACK;
                WRITE:   state_q <= ACK;
                default: state_q <= IDLE;   // ACK lasts one cycle
            endcase

            // Only the two delta words are writable
            if (state_q == WRITE && ctl_req_i.adr[6]) begin
                if (word_sel == 4'd0)
                    scale_delta_q <= ctl_req_i.dat[16:0];
                else if (word_sel == 4'd1)
                    offset_delta_q <= ctl_req_i.dat[15:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (state_q == READ) rsp_dat_q <= rd_dat;
    end

    assign ctl_rsp_o.ack = (state_q == ACK);
    assign ctl_rsp_o.err = 1'b0;
    assign ctl_rsp_o.rty = 1'b0;
    assign ctl_rsp_o.dat = rsp_dat_q;

    assign scale_delta_o  = scale_delta_q;
    assign offset_delta_o = offset_delta_q;

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/agc_bus_pkg.sv
source/agc_loop_pkg.sv
source/agc_gain_calc.sv
source/agc_bus_master.sv
source/agc_reg_target.sv
source/agc_loop_sequencer.sv
source/agc_control_top.sv
test/agc_checker.sv
test/tb_agc_control.sv

/* test/agc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module agc_checker
    import agc_bus_pkg::*;
(
    input  logic    aclk,
    input  logic    wb_rst_i,
    input  logic    agc_reset_i,
    input  wb_req_t ctl_req_i,
    input  wb_rsp_t ctl_rsp_i,
    input  wb_req_t mod_req_i,
    input  wb_rsp_t mod_rsp_i,
    output int      wr_errors,
    output int      rd_errors,
    output int      rounds
);

    logic [31:0] info_mirror [0:5];     // What the DUT should hold for read-back
    logic [31:0] row_word [0:5];        // Words read downstream this round
    logic [16:0] exp_scale;
    logic [15:0] exp_offset;
    logic [16:0] scale_delta;
    logic [15:0] offset_delta;
    logic [31:0] exp_adr;
    logic [31:0] exp_dat;
    logic [31:0] ms;
    int          step;                  // Position in the six-write round
    int          phase;                 // 0 idle, 1 polling, 2 info reads
    int          cyc_cnt;
    int          up_req_cyc;
    logic        up_busy;
    logic        skip_ack;

    initial begin
        wr_errors = 0;
        rd_errors = 0;
        rounds    = 0;
        cyc_cnt   = 0;
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp, input logic is_read);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            if (is_read) rd_errors++;
            else         wr_errors++;
        end
    endtask

    // Gain rule, applied to the row just read
    task automatic update_expected();
        logic [16:0] cur_s;
        logic [15:0] cur_o;
        ms    = row_word[1] >> (17 - `AGC_TIMESCALE_BITS);
        cur_s = row_word[4][16:0];
        cur_o = row_word[5][15:0];
        if (ms > 32'(`AGC_TARGET_RMS_SQ + `AGC_RMS_SQ_ERR)) begin
            exp_scale = (cur_s > 17'h0012C) ? cur_s - scale_delta : cur_s;
        end else if (ms < 32'(`AGC_TARGET_RMS_SQ - `AGC_RMS_SQ_ERR)) begin
            exp_scale = (cur_s < 17'h1FBD0) ? cur_s + scale_delta : cur_s;
        end
        if (longint'(row_word[2]) > longint'(row_word[3]) + `AGC_OFFSET_ERR)
            exp_offset = cur_o - offset_delta;
        else if (longint'(row_word[3]) > longint'(row_word[2]) + `AGC_OFFSET_ERR)
            exp_offset = cur_o + offset_delta;
    endtask

    task automatic check_write();
        case (step)
            0: begin exp_adr = 32'h10; exp_dat = {15'h0, exp_scale}; end
            1: begin exp_adr = 32'h14; exp_dat = {{16{exp_offset[15]}}, exp_offset}; end
            2: begin exp_adr = 32'h00; exp_dat = 32'h300; end
            3: begin exp_adr = 32'h00; exp_dat = 32'h400; end
            4: begin exp_adr = 32'h00; exp_dat = 32'h004; end
            default: begin exp_adr = 32'h00; exp_dat = 32'h001; end
        endcase
        compare("mod_req_o.adr", {24'h0, mod_req_i.adr}, exp_adr, 1'b0);
        compare("mod_req_o.dat", mod_req_i.dat, exp_dat, 1'b0);
        if (step == 3) begin
            info_mirror[4] = {15'h0, exp_scale};    // Applied values land in words 4 and 5
            info_mirror[5] = {16'h0, exp_offset};
        end
        if (step == 5) phase = 1;
        step = (step + 1) % 6;
    endtask

    task automatic handle_read();
        int idx;
        idx = int'(mod_req_i.adr[4:2]);
        if (phase == 1) begin
            if (mod_req_i.adr != 8'h00) begin
                $display("Status poll went to address %h instead of 00", mod_req_i.adr);
                wr_errors++;
            end
            if (mod_rsp_i.dat[`AGC_STATUS_DONE_BIT]) phase = 2;
        end else if (phase == 2) begin
            row_word[idx]    = mod_rsp_i.dat;
            info_mirror[idx] = mod_rsp_i.dat;
            if (idx == 5) begin
                update_expected();
                phase = 0;
                rounds++;
            end
        end else begin
            $display("Downstream read at address %h outside a poll or info phase",
                     mod_req_i.adr);
            wr_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Downstream bus
    ////////////////////////////////////////////////////////////////////
    always @(posedge aclk) begin
        cyc_cnt++;
        if (wb_rst_i || agc_reset_i) begin
            if (wb_rst_i) begin
                scale_delta  = 17'd30;
                offset_delta = 16'd25;
                up_busy      = 1'b0;
            end
            exp_scale  = 17'd1500;
            exp_offset = 16'd0;
            step       = 0;
            phase      = 0;
            skip_ack   = mod_req_i.cyc && !mod_rsp_i.ack;  // Access still in flight
            for (int i = 0; i < 6; i++) info_mirror[i] = 32'h0;
        end else if (mod_req_i.cyc && mod_req_i.stb && mod_rsp_i.ack) begin
            compare("mod_req_o.sel", {28'h0, mod_req_i.sel}, 32'hF, 1'b0);
            if (skip_ack)         skip_ack = 1'b0;
            else if (mod_req_i.we) check_write();
            else                   handle_read();
        end

        // Upstream target, ack two cycles after the request
        if (!wb_rst_i) begin
            compare("ctl_rsp_o.err", {31'h0, ctl_rsp_i.err}, 32'h0, 1'b1);
            compare("ctl_rsp_o.rty", {31'h0, ctl_rsp_i.rty}, 32'h0, 1'b1);
            if (ctl_rsp_i.ack) begin
                if (!up_busy || cyc_cnt != up_req_cyc + 2) begin
                    $display("Upstream ack came at the wrong cycle");
                    rd_errors++;
                end
                up_busy = 1'b0;
                if (ctl_req_i.we && ctl_req_i.adr[6]) begin
                    if (ctl_req_i.adr[5:2] == 4'd0) scale_delta = ctl_req_i.dat[16:0];
                    if (ctl_req_i.adr[5:2] == 4'd1) offset_delta = ctl_req_i.dat[15:0];
                end else if (!ctl_req_i.we) begin
                    exp_dat = 32'h0;
                    if (ctl_req_i.adr[6]) begin
                        if (ctl_req_i.adr[5:2] == 4'd0) exp_dat = {15'h0, scale_delta};
                        if (ctl_req_i.adr[5:2] == 4'd1)
                            exp_dat = {{16{offset_delta[15]}}, offset_delta};
                    end else if (ctl_req_i.adr[5:2] < 4'd6) begin
                        exp_dat = info_mirror[int'(ctl_req_i.adr[5:2])];
                    end
                    compare("ctl_rsp_o.dat", ctl_rsp_i.dat, exp_dat, 1'b1);
                end
            end else if (ctl_req_i.cyc && ctl_req_i.stb && !up_busy) begin
                up_busy    = 1'b1;
                up_req_cyc = cyc_cnt;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_agc_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module tb_agc_control
    import agc_bus_pkg::*;
();

    localparam int  ROWS       = 8;
    localparam int  ROW_BUDGET = 400;     // Cycles per round
    localparam real PERIOD     = 40.0;

    typedef struct packed {
        logic [5:0][31:0] word;
        logic [7:0]       delay;            // Base ack delay
        logic             wr_delta;         // Host rewrites the deltas this round
        logic [31:0]      sdelta;
        logic [31:0]      odelta;
    } row_t;

    logic    aclk;
    logic    wb_rst_i;
    logic    agc_reset_i;
    wb_req_t ctl_req;
    wb_rsp_t ctl_rsp;
    wb_req_t mod_req;
    wb_rsp_t mod_rsp;

    row_t table_q [0:ROWS-1];
    int   cur_row;
    int   seed;
    int   ack_wait;
    logic pending;
    logic info_phase;
    int   poll_cnt;
    int   offset_writes;
    int   apply_writes;
    int   tb_errors;
    int   base;
    int   wr_errors;
    int   rd_errors;
    int   rounds;

    agc_control_top i_dut (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .ctl_req_i   (ctl_req),
        .ctl_rsp_o   (ctl_rsp),
        .mod_req_o   (mod_req),
        .mod_rsp_i   (mod_rsp)
    );

    agc_checker i_checker (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .ctl_req_i   (ctl_req),
        .ctl_rsp_i   (ctl_rsp),
        .mod_req_i   (mod_req),
        .mod_rsp_i   (mod_rsp),
        .wr_errors   (wr_errors),
        .rd_errors   (rd_errors),
        .rounds      (rounds)
    );

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2.0) aclk = ~aclk;
    end

    task automatic set_row(input int r, input logic [31:0] w0, input logic [31:0] w1,
                           input logic [31:0] w2, input logic [31:0] w3,
                           input logic [31:0] w4, input logic [31:0] w5,
                           input logic [7:0] delay, input logic wr,
                           input logic [31:0] sd, input logic [31:0] od);
        table_q[r].word     = {w5, w4, w3, w2, w1, w0};
        table_q[r].delay    = delay;
        table_q[r].wr_delta = wr;
        table_q[r].sdelta   = sd;
        table_q[r].odelta   = od;
    endtask

    task automatic host_access(input logic we, input logic [7:0] adr, input logic [31:0] dat);
        int waited;
        waited      = 0;
        ctl_req.cyc = 1'b1;
        ctl_req.stb = 1'b1;
        ctl_req.we  = we;
        ctl_req.adr = adr;
        ctl_req.sel = 4'hF;
        ctl_req.dat = dat;
        @(negedge aclk);
        while (!ctl_rsp.ack && waited < 8) begin
            @(negedge aclk);
            waited++;
        end
        if (!ctl_rsp.ack) begin
            $display("Upstream access to address %h got no ack", adr);
            tb_errors++;
        end
        @(negedge aclk);                    // Request held through the ack cycle
        ctl_req = '0;
        @(negedge aclk);
    endtask

    ////////////////////////////////////////////////////////////////////
    // AGC module model
    ////////////////////////////////////////////////////////////////////
    task automatic answer_request();
        logic [2:0] idx;
        idx         = mod_req.adr[4:2];
        mod_rsp.ack = 1'b1;
        mod_rsp.dat = 32'h0;
        if (mod_req.we) begin
            if (mod_req.adr == `AGC_ADR_OFFSET) offset_writes++;
            if (mod_req.adr == `AGC_ADR_CTRL && mod_req.dat == `AGC_CMD_APPLY) apply_writes++;
            if (mod_req.adr == `AGC_ADR_CTRL && mod_req.dat == `AGC_CMD_START) begin
                poll_cnt   = 0;     // New sample cycle
                info_phase = 1'b0;
            end
        end else if (!info_phase && mod_req.adr == `AGC_ADR_CTRL) begin
            poll_cnt++;
            if (poll_cnt >= 2) begin
                mod_rsp.dat[`AGC_STATUS_DONE_BIT] = 1'b1;
                info_phase = 1'b1;
            end
        end else if (idx < 3'd6) begin
            mod_rsp.dat = table_q[cur_row].word[idx];
        end
    endtask

    always @(negedge aclk) begin
        if (wb_rst_i) begin
            mod_rsp       = '0;
            pending       = 1'b0;
            poll_cnt      = 0;
            info_phase    = 1'b0;
            offset_writes = 0;
            apply_writes  = 0;
        end else if (mod_rsp.ack) begin
            mod_rsp.ack = 1'b0;     // Ack lasts one cycle
            pending     = 1'b0;
        end else if (mod_req.cyc && mod_req.stb) begin
            if (!pending) begin
                pending  = 1'b1;
                ack_wait = int'(table_q[cur_row].delay) + ($random(seed) & 3);
            end
            if (ack_wait == 0) answer_request();
            else               ack_wait--;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus table loop
    ////////////////////////////////////////////////////////////////////
    initial begin
        seed        = 32'hd295_bb19;
        ctl_req     = '0;
        mod_rsp     = '0;
        agc_reset_i = 1'b0;
        wb_rst_i    = 1'b1;
        cur_row     = 0;
        tb_errors   = 0;
        // Scale down with offset down, scale up with offset up, hold, min cutoff,
        // max cutoff, near-band moves
        set_row(0, 32'h11, 32'h40000, 100, 50, 32'h5DC, 32'h0, 8'd1, 1'b0, 0, 0);
        set_row(1, 32'h22, 32'h10000, 50, 100, 32'h5DC, 32'hFFE7, 8'd0, 1'b0, 0, 0);
        set_row(2, 32'h33, 32'h20000, 60, 62, 32'h600, 32'hA, 8'd3, 1'b0, 0, 0);
        set_row(3, 32'h44, 32'h80000, 10, 10, 32'h12C, 32'h0, 8'd2, 1'b1,
                32'h40, 32'hFFFF_FFFD);
        set_row(4, 32'h55, 32'h08000, 5, 200, 32'h1FBD0, 32'h5, 8'd1, 1'b0, 0, 0);
        set_row(5, 32'h66, 32'h1FFFF, 300, 0, 32'h12D, 32'hFFF0, 8'd4, 1'b0, 0, 0);
        set_row(6, 32'h77, 32'h22000, 20, 26, 32'h12D, 32'h3, 8'd0, 1'b1, 32'h100, 32'h7);
        set_row(7, 32'h88, 32'h20000, 7, 2, 32'h1000, 32'h20, 8'd2, 1'b0, 0, 0);
        repeat (8) @(negedge aclk);
        wb_rst_i = 1'b0;

        for (int r = 0; r < ROWS; r++) begin
            while (apply_writes < r + 1) @(negedge aclk);
            if (table_q[r].wr_delta) begin
                host_access(1'b1, 8'h40, table_q[r].sdelta);
                host_access(1'b1, 8'h44, table_q[r].odelta);
            end
            host_access(1'b0, 8'h40, 32'h0);
            host_access(1'b0, 8'h44, 32'h0);
            host_access(1'b0, 8'h10, 32'h0);    // Applied scale
            host_access(1'b0, 8'h14, 32'h0);
            while (offset_writes < r + 2) @(negedge aclk);
            if (r + 1 < ROWS) cur_row = r + 1;
        end

        // Restart mid-round while status is being polled
        while (!(mod_req.cyc && !mod_req.we && mod_req.adr == 8'h00 && !info_phase))
            @(negedge aclk);
        agc_reset_i = 1'b1;
        @(negedge aclk);
        agc_reset_i = 1'b0;
        base = offset_writes;
        while (offset_writes < base + 2) @(negedge aclk);
        repeat (4) @(negedge aclk);

        if (rounds < ROWS + 1) begin
            $display("Only %0d of %0d rounds completed", rounds, ROWS + 1);
            tb_errors++;
        end
        $display("Errors: downstream %0d, upstream %0d, testbench %0d",
                 wr_errors, rd_errors, tb_errors);
        if (wr_errors + rd_errors + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, one budget per table row plus the restart round
    initial begin
        #(PERIOD * ROW_BUDGET * (ROWS + 1));
        $display("Watchdog expired before the last round finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
